// File: flist.f
+incdir+source
source/sm_ctrl_pkg.sv
source/sm_buf_pkg.sv
source/sm_ctrl_fsm.sv
source/sm_phase_timer.sv
source/sm_row_addr_gen.sv
source/sm_buf_port.sv
source/sm_seq_top.sv
sim/sm_seq_chk.sv
sim/sm_seq_tb.sv

// File: sim/sm_seq_chk.sv
module sm_seq_chk import sm_ctrl_pkg::*, sm_buf_pkg::*; (
    input logic       core_clk,
    input logic       rst_n,
    input logic       sm_end,
    input rd_port_t   lbuf_rd,
    input rd_port_t   cache_rd,
    input wr_port_t   lbuf_wr,
    input wr_port_t   cache_wr,
    input lane_ctrl_t lane_ctrl
);

    timeunit 1ns;
    timeprecision 100ps;

    int err_cnt = 0;   // failures so far, watched by the testbench

    end_pulse: assert property (@(posedge core_clk) disable iff (!rst_n) sm_end |=> !sm_end)
        else begin
            $error("sm_end held for more than one cycle");
            err_cnt++;
        end

    // both buffers are dual port, a clash on the same word is the hazard
    lbuf_clash: assert property (@(posedge core_clk) disable iff (!rst_n)
        !(lbuf_rd.ren && lbuf_wr.wen && lbuf_rd.raddr == lbuf_wr.waddr))
        else begin
            $error("lbuf word read and written in one cycle");
            err_cnt++;
        end

    cache_clash: assert property (@(posedge core_clk) disable iff (!rst_n)
        !(cache_rd.ren && cache_wr.wen && cache_rd.raddr == cache_wr.waddr))
        else begin
            $error("cache word read and written in one cycle");
            err_cnt++;
        end

    reci_pulse: assert property (@(posedge core_clk) disable iff (!rst_n)
        lane_ctrl.reci_en |=> !lane_ctrl.reci_en)
        else begin
            $error("reci_en set in two consecutive cycles");
            err_cnt++;
        end

endmodule

bind sm_seq_top sm_seq_chk chk (.*);

// File: sim/sm_seq_tb.sv
`include "sm_params.svh"

module sm_seq_tb import sm_ctrl_pkg::*, sm_buf_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int W   = `SM_ROW_W;
    localparam int AW  = `SM_LBUF_AW;
    localparam int TMO = 2000;   // cycles allowed per job

    logic         core_clk;
    logic         rst_n;
    logic         sm_start;
    sm_op_e       sm_op;
    job_cfg_t     cfg;
    logic         sm_end;
    rd_port_t     lbuf_rd;
    rd_port_t     cache_rd;
    wr_port_t     lbuf_wr;
    wr_port_t     cache_wr;
    lane_ctrl_t   lane_ctrl;
    logic [W-1:0] lbuf_rdata;
    logic [W-1:0] cache_rdata;
    logic [W-1:0] lane_in;
    logic [W-1:0] lane_out;
    logic         reci_done;

    integer       seed;
    int           cyc;
    int           start_cyc;
    int           end_cyc;
    int           reci_at;
    int           reci_total;
    int           units;
    int           n_lrd;
    int           n_crd;
    int           n_cwr;
    int           n_lwr;
    int           n_reci;
    logic         busy;
    logic         reci_pend;
    logic [W-1:0] lb_mem [8];   // read data slots, indexed by cycle
    logic [W-1:0] cm_mem [8];
    logic [7:0]   lb_vld;
    logic [7:0]   cm_vld;
    logic [7:0]   add_vld;      // adder_en expected, by cycle slot
    logic [W-1:0] max_q [$];    // lbuf words read in MAX

    sm_seq_top dut (.*);

    function automatic logic [W-1:0] rand_word();
        logic [W-1:0] w;
        for (int i = 0; i < W / 32; i++) begin
            w[i*32 +: 32] = $random(seed);
        end
        return w;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "run stopped at cycle %0d", cyc);
    endtask

    initial begin
        core_clk = 1'b0;
        forever #5 core_clk = ~core_clk;
    end

    ////////////////////
    // buffer and lane array models
    ////////////////////
    always @(posedge core_clk) begin
        cyc = cyc + 1;
        #1;
        lane_out    = rand_word();
        lbuf_rdata  = lb_mem[cyc % 8];
        cache_rdata = cm_mem[cyc % 8];
        reci_done   = (cyc == reci_at);   // 1 to 8 cycles after reci_en
    end

    ////////////////////
    // scoreboard, sampled mid cycle
    ////////////////////
    always @(negedge core_clk) begin
        int           row;
        int           off;
        int           d;
        logic [AW-1:0] exp_addr;
        logic [W-1:0]  exp_data;
        logic          exp_rst;
        logic          exp_cmp;
        logic          exp_add;
        assert (dut.chk.err_cnt == 0)
            else stop_run("concurrent assertion in sm_seq_chk failed");
        // MAX compares each lbuf word as it arrives
        exp_cmp          = lb_vld[cyc % 8] && (sm_op == OP_MAX_PWL);
        exp_add          = add_vld[cyc % 8];
        add_vld[cyc % 8] = 1'b0;
        if (lb_vld[cyc % 8]) begin
            assert (lane_in === lbuf_rdata)
                else stop_run($sformatf("FAILED lane_in got %h exp %h", lane_in, lbuf_rdata));
            lb_vld[cyc % 8] = 1'b0;
        end
        if (cm_vld[cyc % 8]) begin
            assert (lane_in === cache_rdata)
                else stop_run($sformatf("FAILED lane_in got %h exp %h", lane_in, cache_rdata));
            cm_vld[cyc % 8] = 1'b0;
        end
        if (!busy) begin
            assert (!lbuf_rd.ren && !cache_rd.ren && !lbuf_wr.wen && !cache_wr.wen
                    && lane_ctrl == '0 && !sm_end)
                else stop_run("strobe or sm_end active while no job runs");
        end else begin
            exp_rst = (sm_op == OP_MAX_PWL) && lbuf_rd.ren && (n_lrd % units == 0);
            if (lbuf_rd.ren) begin
                row      = n_lrd / units;
                off      = n_lrd % units;
                exp_addr = AW'(cfg.im_base_addr + row * cfg.ifm_addr_align + off);
                assert (lbuf_rd.raddr === exp_addr)
                    else stop_run($sformatf("FAILED lbuf_rd.raddr got %h exp %h",
                                            lbuf_rd.raddr, exp_addr));
                lb_mem[(cyc + `SM_LBUF_RLAT) % 8] = rand_word();
                lb_vld[(cyc + `SM_LBUF_RLAT) % 8] = 1'b1;
                if (sm_op == OP_MAX_PWL) begin
                    max_q.push_back(lb_mem[(cyc + `SM_LBUF_RLAT) % 8]);
                end else begin
                    add_vld[(cyc + `SM_LBUF_RLAT + `SM_EXP_LAT) % 8] = 1'b1;
                end
                n_lrd++;
            end
            if (reci_done) reci_pend = 1'b0;
            if (cache_rd.ren) begin
                assert (!reci_pend) else stop_run("cache read while reciprocal still pending");
                assert (cache_rd.raddr === AW'(n_crd % units))
                    else stop_run($sformatf("FAILED cache_rd.raddr got %h exp %h",
                                            cache_rd.raddr, AW'(n_crd % units)));
                cm_mem[(cyc + `SM_CACHE_RLAT) % 8] = rand_word();
                cm_vld[(cyc + `SM_CACHE_RLAT) % 8] = 1'b1;
                // first half of an op 0 row's cache reads feed EXP_A
                if (sm_op == OP_MAX_PWL && (n_crd % (2 * units)) < units) begin
                    add_vld[(cyc + `SM_CACHE_RLAT + `SM_EXP_LAT) % 8] = 1'b1;
                end
                n_crd++;
            end
            if (cache_wr.wen) begin
                assert (cache_wr.waddr === AW'(n_cwr % units))
                    else stop_run($sformatf("FAILED cache_wr.waddr got %h exp %h",
                                            cache_wr.waddr, AW'(n_cwr % units)));
                // op 0 rows write the raw words first, then the exponents
                if (sm_op == OP_MAX_PWL && (n_cwr % (2 * units)) < units) begin
                    exp_data = max_q.pop_front();
                end else begin
                    exp_data = lane_out;
                end
                assert (cache_wr.wdata === exp_data)
                    else stop_run($sformatf("FAILED cache_wr.wdata got %h exp %h",
                                            cache_wr.wdata, exp_data));
                n_cwr++;
            end
            if (lbuf_wr.wen) begin
                row      = n_lwr / units;
                off      = n_lwr % units;
                exp_addr = AW'(cfg.om_base_addr + row * cfg.ofm_addr_align + off);
                assert (lbuf_wr.waddr === exp_addr)
                    else stop_run($sformatf("FAILED lbuf_wr.waddr got %h exp %h",
                                            lbuf_wr.waddr, exp_addr));
                assert (lbuf_wr.wdata === lane_out)
                    else stop_run($sformatf("FAILED lbuf_wr.wdata got %h exp %h",
                                            lbuf_wr.wdata, lane_out));
                n_lwr++;
            end
            if (lane_ctrl.reci_en) begin
                d           = 1 + $unsigned($random(seed)) % 8;
                reci_at     = cyc + d;
                reci_total += d + 1;   // RECI ends the cycle after reci_done
                reci_pend   = 1'b1;
                n_reci++;
            end
            assert (lane_ctrl.comp_rst === exp_rst)
                else stop_run($sformatf("FAILED lane_ctrl.comp_rst got %h exp %h",
                                        lane_ctrl.comp_rst, exp_rst));
            assert (lane_ctrl.comp_en === exp_cmp)
                else stop_run($sformatf("FAILED lane_ctrl.comp_en got %h exp %h",
                                        lane_ctrl.comp_en, exp_cmp));
            assert (lane_ctrl.adder_en === exp_add)
                else stop_run($sformatf("FAILED lane_ctrl.adder_en got %h exp %h",
                                        lane_ctrl.adder_en, exp_add));
            if (sm_end) begin
                busy    = 1'b0;
                end_cyc = cyc;
            end
        end
    end

    task automatic run_job();
        job_cfg_t c;
        sm_op_e   op;
        int       rows;
        int       row_len;
        int       n;
        @(posedge core_clk);
        units             = 1 + $unsigned($random(seed)) % 6;
        rows              = 1 + $unsigned($random(seed)) % 4;
        op                = sm_op_e'($random(seed) & 1);
        c.channel_number  = `SM_CH_W'(units * 8 + ($random(seed) & 7));
        c.im_base_addr    = 16'($random(seed));
        c.om_base_addr    = 16'($random(seed));
        c.ifm_addr_align  = 12'($random(seed));
        c.ofm_addr_align  = 12'($random(seed));
        c.token_per_block = 12'(rows);
        #1;
        cfg        = c;
        sm_op      = op;
        n_lrd      = 0;
        n_crd      = 0;
        n_cwr      = 0;
        n_lwr      = 0;
        n_reci     = 0;
        reci_total = 0;
        max_q.delete();
        sm_start  = 1'b1;
        busy      = 1'b1;
        start_cyc = cyc;
        @(posedge core_clk);
        #1 sm_start = 1'b0;
        repeat (2) @(posedge core_clk);
        #1 sm_start = 1'b1;   // start while busy, must be ignored
        @(posedge core_clk);
        #1 sm_start = 1'b0;
        for (n = 0; n < TMO && busy; n++) begin
            @(posedge core_clk);
        end
        if (busy) stop_run("timeout waiting for sm_end");
        // EXP_B plus EXP_A, and MAX only in op 0
        row_len = units + `SM_CACHE_RLAT + `SM_NORM_LAT;
        if (op == OP_MAX_PWL) begin
            row_len += (units + `SM_LBUF_RLAT) + (units + `SM_CACHE_RLAT + `SM_EXP_LAT);
        end else begin
            row_len += units + `SM_LBUF_RLAT + `SM_EXP_LAT;
        end
        assert (end_cyc == start_cyc + 1 + rows * row_len + reci_total)
            else stop_run($sformatf("FAILED sm_end cycle got %h exp %h",
                                    end_cyc, start_cyc + 1 + rows * row_len + reci_total));
        assert (n_lrd == rows * units && n_lwr == rows * units && n_reci == rows)
            else stop_run("wrong number of lbuf reads, lbuf writes or reci_en pulses");
        assert (n_crd == n_cwr && n_cwr == rows * units * ((op == OP_MAX_PWL) ? 2 : 1))
            else stop_run("wrong number of cache reads or cache writes");
    endtask

    initial begin
        seed        = 32'hdd455ca8;
        cyc         = 0;
        reci_at     = -1;
        units       = 1;
        busy        = 1'b0;
        reci_pend   = 1'b0;
        lb_vld      = '0;
        cm_vld      = '0;
        add_vld     = '0;
        foreach (lb_mem[i]) begin
            lb_mem[i] = '0;
            cm_mem[i] = '0;
        end
        rst_n       = 1'b0;
        sm_start    = 1'b0;
        sm_op       = OP_MAX_PWL;
        cfg         = '0;
        lane_out    = '0;
        lbuf_rdata  = '0;
        cache_rdata = '0;
        reci_done   = 1'b0;
        repeat (2) @(posedge core_clk);
        #1 rst_n = 1'b1;
        repeat (3) @(posedge core_clk);
        for (int j = 0; j < 16; j++) begin
            run_job();
        end
        repeat (4) @(posedge core_clk);
        if (dut.chk.err_cnt == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1, "%0d assertion failures", dut.chk.err_cnt);
        end
    end

endmodule

// File: source/sm_buf_pkg.sv
`include "sm_params.svh"

package sm_buf_pkg;

    ////////////////////
    // job settings
    ////////////////////
    // held stable by the host while a job runs
    typedef struct packed {
        logic [`SM_CH_W-1:0] channel_number;
        logic [15:0]         im_base_addr;
        logic [15:0]         om_base_addr;
        logic [11:0]         ifm_addr_align;   // row stride of the input
        logic [11:0]         ofm_addr_align;   // row stride of the output
        logic [11:0]         token_per_block;  // rows per job
    } job_cfg_t;

    ////////////////////
    // buffer ports
    ////////////////////
    typedef struct packed {
        logic                   ren;
        logic [`SM_LBUF_AW-1:0] raddr;
    } rd_port_t;

    typedef struct packed {
        logic                   wen;
        logic [`SM_LBUF_AW-1:0] waddr;
        logic [`SM_ROW_W-1:0]   wdata;
    } wr_port_t;

    // cache ports reuse these, upper address bits tied low

endpackage

// File: source/sm_buf_port.sv
`include "sm_params.svh"

module sm_buf_port import sm_ctrl_pkg::*, sm_buf_pkg::*; (
    input  sm_phase_e              state,
    input  sm_op_e                 sm_op,
    input  phase_win_t             win,
    input  logic [`SM_LBUF_AW-1:0] lbuf_raddr,
    input  logic [`SM_LBUF_AW-1:0] lbuf_waddr,
    input  logic [`SM_ROW_W-1:0]   lbuf_rdata,
    input  logic [`SM_ROW_W-1:0]   cache_rdata,
    input  logic [`SM_ROW_W-1:0]   lane_out,
    output rd_port_t               lbuf_rd,
    output rd_port_t               cache_rd,
    output wr_port_t               lbuf_wr,
    output wr_port_t               cache_wr,
    output lane_ctrl_t             lane_ctrl,
    output logic [`SM_ROW_W-1:0]   lane_in
);

    localparam int AW = `SM_LBUF_AW;

    logic in_max;
    logic in_exp_a;
    logic in_exp_b;
    logic lbuf_src;   // lane array fed from lbuf

    assign in_max   = (state == MAX);
    assign in_exp_a = (state == EXP_A);
    assign in_exp_b = (state == EXP_B);
    assign lbuf_src = in_max || (in_exp_a && sm_op == OP_LUT);

    ////////////////////
    // buffer strobes
    ////////////////////
    assign lbuf_rd.ren    = win.rd && lbuf_src;
    assign lbuf_rd.raddr  = lbuf_raddr;

    assign cache_rd.ren   = win.rd && (in_exp_b || (in_exp_a && sm_op == OP_MAX_PWL));
    assign cache_rd.raddr = AW'(win.rd_idx);

    // max pass stores the raw row, exp pass stores exponents
    assign cache_wr.wen   = win.wr && (in_max || in_exp_a);
    assign cache_wr.waddr = AW'(win.wr_idx);
    assign cache_wr.wdata = in_max ? lbuf_rdata : lane_out;

    assign lbuf_wr.wen    = win.wr && in_exp_b;   // normalized result out
    assign lbuf_wr.waddr  = lbuf_waddr;
    assign lbuf_wr.wdata  = lane_out;

    assign lane_in = lbuf_src ? lbuf_rdata : cache_rdata;

    // lane array control
    assign lane_ctrl.comp_rst = in_max && win.first;
    assign lane_ctrl.comp_en  = in_max && win.wr;
    assign lane_ctrl.adder_en = in_exp_a && win.wr;
    assign lane_ctrl.reci_en  = (state == RECI) && win.first;

endmodule

// File: source/sm_ctrl_fsm.sv
`include "sm_params.svh"

module sm_ctrl_fsm import sm_ctrl_pkg::*; (
    input  logic       core_clk,
    input  logic       rst_n,
    input  logic       sm_start,
    input  sm_op_e     sm_op,
    input  phase_win_t win,
    input  logic       reci_done,
    input  logic       last_row,
    output sm_phase_e  state,
    output logic       sm_end
);

    sm_phase_e next_state;
    sm_phase_e row_entry;   // first phase of a row

    assign row_entry = (sm_op == OP_MAX_PWL) ? MAX : EXP_A;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (sm_start) begin
                    next_state = row_entry;
                end
            end
            MAX: begin
                if (win.done) next_state = EXP_A;
            end
            EXP_A: begin
                if (win.done) next_state = RECI;
            end
            RECI: begin
                if (reci_done) next_state = EXP_B;  // wait length set by lane array
            end
            EXP_B: begin
                if (win.done) begin
                    next_state = last_row ? IDLE : row_entry;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // end of job, one cycle after the last normalize cycle
    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            sm_end <= 1'b0;
        end else begin
            sm_end <= (state == EXP_B) && win.done && last_row;
        end
    end

endmodule

// File: source/sm_ctrl_pkg.sv
`include "sm_params.svh"

package sm_ctrl_pkg;

    // row phases of the sequencer
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        MAX   = 3'd1,   // row max, op 0 only
        EXP_A = 3'd2,   // exponent and sum
        RECI  = 3'd3,   // wait on reciprocal
        EXP_B = 3'd4    // normalize
    } sm_phase_e;

    typedef enum logic {
        OP_MAX_PWL = 1'b0,  // with max pass
        OP_LUT     = 1'b1   // no max pass
    } sm_op_e;

    // per cycle timing of the current phase
    typedef struct packed {
        logic                    first;
        logic                    rd;
        logic                    wr;
        logic                    done;
        logic [`SM_CACHE_AW-1:0] rd_idx;
        logic [`SM_CACHE_AW-1:0] wr_idx;
    } phase_win_t;

    typedef struct packed {
        logic comp_en;
        logic comp_rst;
        logic adder_en;
        logic reci_en;
    } lane_ctrl_t;

endpackage

// File: source/sm_params.svh
`ifndef SM_PARAMS_SVH
`define SM_PARAMS_SVH

////////////////////
// datapath geometry
////////////////////
`define SM_LANES       16
`define SM_LANE_W      64
`define SM_ROW_W       (`SM_LANES * `SM_LANE_W)   // one buffer word

// address and field widths
`define SM_LBUF_AW     13
`define SM_CACHE_AW    9
`define SM_CH_W        13

////////////////////
// pipeline latencies
////////////////////
`define SM_LBUF_RLAT   3    // lbuf ren to rdata
`define SM_CACHE_RLAT  2    // cache ren to rdata
`define SM_EXP_LAT     3    // exponent unit
`define SM_NORM_LAT    2    // multiply plus output stage

`endif

// File: source/sm_phase_timer.sv
`include "sm_params.svh"

module sm_phase_timer import sm_ctrl_pkg::*; (
    input  logic                core_clk,
    input  logic                rst_n,
    input  sm_phase_e           state,
    input  sm_op_e              sm_op,
    input  logic [`SM_CH_W-1:0] channel_number,
    output phase_win_t          win
);

    localparam int CNT_W = `SM_CH_W - 2;   // units plus the longest latency

    logic [CNT_W-1:0] units;
    logic [CNT_W-1:0] lat;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] wr_off;
    sm_phase_e        state_q;
    logic             phase_chg;
    logic             data_phase;

    assign units = CNT_W'(channel_number >> 3);   // 8 channels per word

    // latency from read strobe to write of the same word
    always_comb begin
        case (state)
            MAX:     lat = CNT_W'(`SM_LBUF_RLAT);
            EXP_A:   lat = (sm_op == OP_MAX_PWL) ? CNT_W'(`SM_CACHE_RLAT + `SM_EXP_LAT)
                                                 : CNT_W'(`SM_LBUF_RLAT + `SM_EXP_LAT);
            EXP_B:   lat = CNT_W'(`SM_CACHE_RLAT + `SM_NORM_LAT);
            default: lat = '0;
        endcase
    end

    ////////////////////
    // phase cycle count
    ////////////////////
    assign phase_chg = (state != state_q);
    assign cnt       = phase_chg ? '0 : cnt_q;   // cycle 0 of a new phase

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state;
            cnt_q   <= (cnt == '1) ? cnt : cnt + 1'b1;  // holds in long waits
        end
    end

    assign data_phase = (state == MAX) || (state == EXP_A) || (state == EXP_B);
    assign wr_off     = cnt - lat;

    assign win.first  = (cnt == '0);
    assign win.rd     = data_phase && (cnt < units);
    assign win.wr     = data_phase && (cnt >= lat) && (cnt < lat + units);
    assign win.done   = data_phase && (cnt == units + lat - 1'b1);
    assign win.rd_idx = cnt[`SM_CACHE_AW-1:0];
    assign win.wr_idx = wr_off[`SM_CACHE_AW-1:0];

endmodule

// File: source/sm_row_addr_gen.sv
`include "sm_params.svh"

module sm_row_addr_gen import sm_ctrl_pkg::*, sm_buf_pkg::*; (
    input  logic                   core_clk,
    input  logic                   rst_n,
    input  sm_phase_e              state,
    input  logic                   sm_start,
    input  job_cfg_t               cfg,
    input  phase_win_t             win,
    output logic [`SM_LBUF_AW-1:0] lbuf_raddr,
    output logic [`SM_LBUF_AW-1:0] lbuf_waddr,
    output logic                   last_row
);

    localparam int AW = `SM_LBUF_AW;

    logic [AW-1:0] rd_base;
    logic [AW-1:0] wr_base;
    logic [11:0]   row_cnt;   // current row, counted from 1
    logic          job_load;
    logic          row_step;

    assign job_load = (state == IDLE) && sm_start;
    assign row_step = (state == EXP_B) && win.done;

    ////////////////////
    // row bases
    ////////////////////
    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_base <= '0;
            wr_base <= '0;
            row_cnt <= '0;
        end else if (job_load) begin
            rd_base <= AW'(cfg.im_base_addr);
            wr_base <= AW'(cfg.om_base_addr);
            row_cnt <= 12'd1;
        end else if (row_step) begin
            rd_base <= rd_base + AW'(cfg.ifm_addr_align);
            wr_base <= wr_base + AW'(cfg.ofm_addr_align);
            row_cnt <= row_cnt + 12'd1;
        end
    end

    assign last_row = (row_cnt == cfg.token_per_block);

    // word offset within the row added on top
    assign lbuf_raddr = rd_base + AW'(win.rd_idx);
    assign lbuf_waddr = wr_base + AW'(win.wr_idx);

endmodule

// File: source/sm_seq_top.sv
`include "sm_params.svh"

module sm_seq_top import sm_ctrl_pkg::*, sm_buf_pkg::*; (
    input  logic                 core_clk,
    input  logic                 rst_n,
    // host side
    input  logic                 sm_start,
    input  sm_op_e               sm_op,
    input  job_cfg_t             cfg,
    output logic                 sm_end,
    // lbuf and cache
    output rd_port_t             lbuf_rd,
    output wr_port_t             lbuf_wr,
    input  logic [`SM_ROW_W-1:0] lbuf_rdata,
    output rd_port_t             cache_rd,
    output wr_port_t             cache_wr,
    input  logic [`SM_ROW_W-1:0] cache_rdata,
    // lane array
    output lane_ctrl_t           lane_ctrl,
    output logic [`SM_ROW_W-1:0] lane_in,
    input  logic [`SM_ROW_W-1:0] lane_out,
    input  logic                 reci_done
);

    sm_phase_e              state;
    phase_win_t             win;
    logic                   last_row;
    logic [`SM_LBUF_AW-1:0] lbuf_raddr;
    logic [`SM_LBUF_AW-1:0] lbuf_waddr;

    sm_ctrl_fsm u_fsm (
        .core_clk  (core_clk),
        .rst_n     (rst_n),
        .sm_start  (sm_start),
        .sm_op     (sm_op),
        .win       (win),
        .reci_done (reci_done),
        .last_row  (last_row),
        .state     (state),
        .sm_end    (sm_end)
    );

    sm_phase_timer u_timer (
        .core_clk       (core_clk),
        .rst_n          (rst_n),
        .state          (state),
        .sm_op          (sm_op),
        .channel_number (cfg.channel_number),
        .win            (win)
    );

    sm_row_addr_gen u_addr (
        .core_clk   (core_clk),
        .rst_n      (rst_n),
        .state      (state),
        .sm_start   (sm_start),
        .cfg        (cfg),
        .win        (win),
        .lbuf_raddr (lbuf_raddr),
        .lbuf_waddr (lbuf_waddr),
        .last_row   (last_row)
    );

    sm_buf_port u_port (
        .state       (state),
        .sm_op       (sm_op),
        .win         (win),
        .lbuf_raddr  (lbuf_raddr),
        .lbuf_waddr  (lbuf_waddr),
        .lbuf_rdata  (lbuf_rdata),
        .cache_rdata (cache_rdata),
        .lane_out    (lane_out),
        .lbuf_rd     (lbuf_rd),
        .cache_rd    (cache_rd),
        .lbuf_wr     (lbuf_wr),
        .cache_wr    (cache_wr),
        .lane_ctrl   (lane_ctrl),
        .lane_in     (lane_in)
    );

endmodule
